// File: design/soc_pkg.sv
////////////////////////////////////////////////////////////
// SoC memory map and bus types
////////////////////////////////////////////////////////////
`default_nettype none

package soc_pkg;

  // processor bus
  localparam int ADDR_W = 24;
  localparam int DATA_W = 32;
  localparam int MASK_W = 4;   // one enable per byte lane

  // block RAM, word addressed
  localparam int RAM_WORDS = 1024;
  localparam int RAM_AW    = 10;

  // IO page, one-hot register select on addr[12:2]
  localparam int IO_PAGE_BIT = 22;
  localparam int IO_SEL_W    = 11;

  // LED-matrix serial port
  localparam int MTX_DIV_W = 3;  // divide by 8
  localparam int MTX_BITS  = 16;
  localparam int MTX_CNT_W = $clog2(MTX_BITS + 1);

  // SPI flash, 8-bit opcode followed by the byte address
  localparam int FLASH_ADDR_W = 24;
  localparam int FLASH_CNT_W  = $clog2(FLASH_ADDR_W + 8 + 1);

  // bit positions in the one-hot IO select
  typedef enum logic [3:0] {
    IO_LEDS     = 4'd0,
    IO_MTX_CTRL = 4'd6,   // read: busy in bit 0
    IO_MTX_DATA = 4'd7,   // write: 16-bit word to send
    IO_FLASH    = 4'd8,   // write: address, read: busy + byte
    IO_BUTTONS  = 4'd10
  } io_reg_e;

  typedef enum logic [7:0] {
    FLASH_READ = 8'h03
  } flash_cmd_e;

  typedef enum logic [1:0] {
    FL_IDLE,
    FL_SEND,
    FL_RECV
  } flash_state_e;

  // request as issued by the core
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [MASK_W-1:0] wmask;
    logic              rstrb;
  } bus_req_t;

  // request as seen by the IO register block
  typedef struct packed {
    logic [IO_SEL_W-1:0] sel;
    logic                wr;
    logic                rd;
    logic [DATA_W-1:0]   wdata;
  } io_req_t;

endpackage

`default_nettype wire

// File: design/soc_ram.sv
////////////////////////////////////////////////////////////
// Byte-masked block RAM
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module soc_ram (
  input  logic                         clk,
  input  logic [soc_pkg::RAM_AW-1:0]   addr,
  input  logic [soc_pkg::DATA_W-1:0]   wdata,
  input  logic [soc_pkg::MASK_W-1:0]   we,
  output logic [soc_pkg::DATA_W-1:0]   rdata
);

  import soc_pkg::*;

  logic [DATA_W-1:0] mem [RAM_WORDS];

  // one write enable per byte lane, maps onto BRAM byte enables
  always_ff @(posedge clk) begin
    for (int i = 0; i < MASK_W; i++) begin
      if (we[i]) begin
        mem[addr][8*i +: 8] <= wdata[8*i +: 8];
      end
    end
  end

  // read port runs every cycle, old data on a same-address write
  always_ff @(posedge clk) begin
    rdata <= mem[addr];
  end

endmodule

`default_nettype wire

// File: design/io_regs.sv
////////////////////////////////////////////////////////////
// IO register block
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module io_regs (
  input  logic                             clk,
  input  logic                             RESET,
  input  soc_pkg::io_req_t                 io,
  output logic [soc_pkg::DATA_W-1:0]       rdata,
  output logic [3:0]                       leds,
  input  logic [5:0]                       buttons,
  output logic                             mtx_start,
  output logic [soc_pkg::MTX_BITS-1:0]     mtx_data,
  input  logic                             mtx_busy,
  output logic                             flash_start,
  output logic [soc_pkg::FLASH_ADDR_W-1:0] flash_addr,
  input  logic                             flash_busy,
  input  logic [7:0]                       flash_data
);

  import soc_pkg::*;

  logic [DATA_W-1:0] rd_mux;
  logic              wr_leds;

  assign wr_leds = io.wr && io.sel[IO_LEDS];

  // engines take their payload straight off the write data
  assign mtx_data   = io.wdata[MTX_BITS-1:0];
  assign flash_addr = io.wdata[FLASH_ADDR_W-1:0];

  // a write to a busy engine is dropped, software polls first
  assign mtx_start   = io.wr && io.sel[IO_MTX_DATA] && !mtx_busy;
  assign flash_start = io.wr && io.sel[IO_FLASH] && !flash_busy;

  always_ff @(posedge clk or negedge RESET) begin
    if (!RESET) begin
      leds <= 4'b0000;
    end else if (wr_leds) begin
      leds <= io.wdata[3:0];
    end
  end

  // sources are ORed, select is one-hot so at most one contributes
  always_comb begin
    rd_mux = '0;
    if (io.sel[IO_LEDS]) begin
      rd_mux = rd_mux | {{(DATA_W-4){1'b0}}, leds};
    end
    if (io.sel[IO_MTX_CTRL]) begin
      rd_mux = rd_mux | {{(DATA_W-1){1'b0}}, mtx_busy};
    end
    if (io.sel[IO_FLASH]) begin
      rd_mux = rd_mux | {{(DATA_W-9){1'b0}}, flash_busy, flash_data};  // status shares the data word
    end
    if (io.sel[IO_BUTTONS]) begin
      rd_mux = rd_mux | {{(DATA_W-6){1'b0}}, buttons};
    end
  end

  // read data only moves on a read strobe
  always_ff @(posedge clk or negedge RESET) begin
    if (!RESET) begin
      rdata <= '0;
    end else if (io.rd) begin
      rdata <= rd_mux;
    end
  end

endmodule

`default_nettype wire

// File: design/matrix_tx.sv
////////////////////////////////////////////////////////////
// LED-matrix serial transmitter
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module matrix_tx (
  input  logic                         clk,
  input  logic                         RESET,
  input  logic                         start,
  input  logic [soc_pkg::MTX_BITS-1:0] data,
  output logic                         busy,
  output logic                         ledmtx_din,
  output logic                         ledmtx_cs,
  output logic                         ledmtx_clk
);

  import soc_pkg::*;

  logic [MTX_DIV_W-1:0] div;
  logic                 tick;
  logic [MTX_CNT_W-1:0] bit_cnt;    // bits left, 0 when idle
  logic [MTX_BITS-1:0]  shifter;

  // divider is never restarted, so the first bit waits up to one period
  always_ff @(posedge clk or negedge RESET) begin
    if (!RESET) begin
      div <= '0;
    end else begin
      div <= div + 1'b1;
    end
  end

  assign tick = (div == '0);
  assign busy = (bit_cnt != '0);

  always_ff @(posedge clk or negedge RESET) begin
    if (!RESET) begin
      bit_cnt <= '0;
    end else if (start) begin
      bit_cnt <= MTX_CNT_W'(MTX_BITS);
    end else if (busy && tick) begin
      bit_cnt <= bit_cnt - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      shifter <= data;
    end else if (busy && tick) begin
      shifter <= {shifter[MTX_BITS-2:0], 1'b0};  // msb first
    end
  end

  // data is stable across the clock pulse and moves as it falls
  assign ledmtx_din = busy && shifter[MTX_BITS-1];
  assign ledmtx_clk = busy && tick;
  assign ledmtx_cs  = !busy;

endmodule

`default_nettype wire

// File: design/flash_reader.sv
////////////////////////////////////////////////////////////
// SPI flash byte reader
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module flash_reader (
  input  logic                             clk,
  input  logic                             RESET,
  input  logic                             start,
  input  logic [soc_pkg::FLASH_ADDR_W-1:0] addr,
  output logic                             busy,
  output logic [7:0]                       data,
  output logic                             spi_mosi,
  input  logic                             spi_miso,
  output logic                             spi_cs_n,
  output logic                             spi_clk
);

  import soc_pkg::*;

  flash_state_e              state;
  logic                      slow_clk;  // half of clk
  logic [FLASH_CNT_W-1:0]    bit_cnt;   // bits left in the current phase
  logic [FLASH_ADDR_W+7:0]   shifter;   // opcode then address
  logic                      last_bit;

  always_ff @(posedge clk or negedge RESET) begin
    if (!RESET) begin
      slow_clk <= 1'b0;
    end else begin
      slow_clk <= ~slow_clk;
    end
  end

  assign last_bit = (bit_cnt == FLASH_CNT_W'(1));

  // bits move at the end of each high phase of the SPI clock
  always_ff @(posedge clk or negedge RESET) begin
    if (!RESET) begin
      state   <= FL_IDLE;
      bit_cnt <= '0;
    end else begin
      case (state)
        FL_IDLE: begin
          if (start) begin
            state   <= FL_SEND;
            bit_cnt <= FLASH_CNT_W'(FLASH_ADDR_W + 8);
          end
        end
        FL_SEND: begin
          if (slow_clk) begin
            if (last_bit) begin
              state   <= FL_RECV;
              bit_cnt <= FLASH_CNT_W'(8);
            end else begin
              bit_cnt <= bit_cnt - 1'b1;
            end
          end
        end
        FL_RECV: begin
          if (slow_clk) begin
            bit_cnt <= bit_cnt - 1'b1;
            if (last_bit) begin
              state <= FL_IDLE;
            end
          end
        end
        default: state <= FL_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == FL_IDLE && start) begin
      shifter <= {FLASH_READ, addr};
    end else if (state == FL_SEND && slow_clk) begin
      shifter <= {shifter[FLASH_ADDR_W+6:0], 1'b0};
    end
  end

  // byte stays readable until the next transfer shifts over it
  always_ff @(posedge clk or negedge RESET) begin
    if (!RESET) begin
      data <= 8'h00;
    end else if (state == FL_RECV && slow_clk) begin
      data <= {data[6:0], spi_miso};
    end
  end

  // cs_n drops with start and lifts on the high phase after the last bit
  always_ff @(posedge clk or negedge RESET) begin
    if (!RESET) begin
      spi_cs_n <= 1'b1;
    end else if (state == FL_IDLE && start) begin
      spi_cs_n <= 1'b0;
    end else if (!busy && slow_clk) begin
      spi_cs_n <= 1'b1;
    end
  end

  assign busy     = (state != FL_IDLE);
  assign spi_clk  = busy && slow_clk;
  assign spi_mosi = (state == FL_SEND) && shifter[FLASH_ADDR_W+7];

endmodule

`default_nettype wire

// File: design/femto_soc.sv
////////////////////////////////////////////////////////////
// Memory and peripheral subsystem
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module femto_soc (
  input  logic                       clk,
  input  logic                       RESET,
  input  soc_pkg::bus_req_t          bus,
  output logic [soc_pkg::DATA_W-1:0] rdata,
  output logic [3:0]                 leds,
  input  logic [5:0]                 buttons,
  output logic                       ledmtx_din,
  output logic                       ledmtx_cs,
  output logic                       ledmtx_clk,
  output logic                       spi_mosi,
  input  logic                       spi_miso,
  output logic                       spi_cs_n,
  output logic                       spi_clk
);

  import soc_pkg::*;

  logic                    is_io;
  logic                    wr;
  logic [MASK_W-1:0]       ram_we;
  logic [DATA_W-1:0]       ram_rdata;
  io_req_t                 io_req;
  logic [DATA_W-1:0]       io_rdata;
  logic                    mtx_start;
  logic [MTX_BITS-1:0]     mtx_data;
  logic                    mtx_busy;
  logic                    flash_start;
  logic [FLASH_ADDR_W-1:0] flash_addr;
  logic                    flash_busy;
  logic [7:0]              flash_data;
  logic                    rd_pend;   // read data due this cycle
  logic                    rd_io;     // page of the pending read
  logic [DATA_W-1:0]       rd_sel;
  logic [DATA_W-1:0]       rd_hold;

  assign is_io  = bus.addr[IO_PAGE_BIT];
  assign wr     = (bus.wmask != '0);
  assign ram_we = is_io ? '0 : bus.wmask;

  always_comb begin
    io_req.sel   = bus.addr[IO_SEL_W+1:2];
    io_req.wr    = wr && is_io;
    io_req.rd    = bus.rstrb && is_io;
    io_req.wdata = bus.wdata;
  end

  soc_ram i_soc_ram (
    .clk   (clk),
    .addr  (bus.addr[RAM_AW+1:2]),
    .wdata (bus.wdata),
    .we    (ram_we),
    .rdata (ram_rdata)
  );

  io_regs i_io_regs (
    .clk         (clk),
    .RESET       (RESET),
    .io          (io_req),
    .rdata       (io_rdata),
    .leds        (leds),
    .buttons     (buttons),
    .mtx_start   (mtx_start),
    .mtx_data    (mtx_data),
    .mtx_busy    (mtx_busy),
    .flash_start (flash_start),
    .flash_addr  (flash_addr),
    .flash_busy  (flash_busy),
    .flash_data  (flash_data)
  );

  matrix_tx i_matrix_tx (
    .clk        (clk),
    .RESET      (RESET),
    .start      (mtx_start),
    .data       (mtx_data),
    .busy       (mtx_busy),
    .ledmtx_din (ledmtx_din),
    .ledmtx_cs  (ledmtx_cs),
    .ledmtx_clk (ledmtx_clk)
  );

  flash_reader i_flash_reader (
    .clk      (clk),
    .RESET    (RESET),
    .start    (flash_start),
    .addr     (flash_addr),
    .busy     (flash_busy),
    .data     (flash_data),
    .spi_mosi (spi_mosi),
    .spi_miso (spi_miso),
    .spi_cs_n (spi_cs_n),
    .spi_clk  (spi_clk)
  );

  always_ff @(posedge clk or negedge RESET) begin
    if (!RESET) begin
      rd_pend <= 1'b0;
      rd_io   <= 1'b0;
    end else begin
      rd_pend <= bus.rstrb;
      if (bus.rstrb) begin
        rd_io <= is_io;
      end
    end
  end

  assign rd_sel = rd_io ? io_rdata : ram_rdata;

  // RAM output follows the address, so keep the last read word
  always_ff @(posedge clk or negedge RESET) begin
    if (!RESET) begin
      rd_hold <= '0;
    end else if (rd_pend) begin
      rd_hold <= rd_sel;
    end
  end

  assign rdata = rd_pend ? rd_sel : rd_hold;

endmodule

`default_nettype wire

// File: verification/femto_soc_asserts.sv
////////////////////////////////////////////////////////////
// Serial port assertions
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module femto_soc_asserts (
  input logic clk,
  input logic RESET,
  input logic busy,
  input logic sclk,      // serial clock of the engine
  input logic sel_idle   // chip select at its idle level
);

  // device deselected, so no clock edges on the wire
  a_sclk_idle: assert property (
    @(posedge clk) disable iff (!RESET) sel_idle |-> !sclk
  ) else $error("serial clock high while chip select is idle");

  a_idle_after_reset: assert property (
    @(posedge clk) $rose(RESET) |-> !busy
  ) else $error("engine busy in the first cycle after reset");

endmodule

bind flash_reader femto_soc_asserts i_flash_asserts (
  .clk      (clk),
  .RESET    (RESET),
  .busy     (busy),
  .sclk     (spi_clk),
  .sel_idle (spi_cs_n)
);

// ledmtx_cs is high while the matrix port is idle
bind matrix_tx femto_soc_asserts i_mtx_asserts (
  .clk      (clk),
  .RESET    (RESET),
  .busy     (busy),
  .sclk     (ledmtx_clk),
  .sel_idle (ledmtx_cs)
);

`default_nettype wire

// File: verification/tb_femto_soc.sv
////////////////////////////////////////////////////////////
// femto SoC testbench
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module tb_femto_soc;

  import soc_pkg::*;

  localparam int CLK_HALF    = 20;      // 40 ns period
  localparam int RESET_CYC   = 16;
  localparam int CYCLE_LIMIT = 20000;   // about ten times the expected run

  typedef struct packed {
    logic              chk;
    logic [DATA_W-1:0] val;
  } rd_exp_t;

  logic              clk = 1'b0;
  logic              RESET;
  bus_req_t          bus;
  logic [DATA_W-1:0] rdata;
  logic [3:0]        leds;
  logic [5:0]        buttons;
  logic              ledmtx_din;
  logic              ledmtx_cs;
  logic              ledmtx_clk;
  logic              spi_mosi;
  logic              spi_miso;
  logic              spi_cs_n;
  logic              spi_clk;

  rd_exp_t           exp_q[$];           // one entry per read in flight
  logic              rd_due = 1'b0;
  logic [DATA_W-1:0] rd_last = '0;       // rdata resets to zero
  event              rd_done;
  logic [DATA_W-1:0] shadow [RAM_WORDS];
  integer            seed = 32'h547f;
  int                cycles = 0;
  int                errors = 0;
  int                checks = 0;
  int                tests_run = 0;
  int                tests_failed = 0;

  logic [15:0]       mtx_word;           // matrix model
  int                mtx_pulses = 0;
  logic [31:0]       fl_cmd;             // flash model
  int                fl_bits = 0;
  logic [7:0]        fl_reply;

  femto_soc i_femto_soc (
    .clk        (clk),
    .RESET      (RESET),
    .bus        (bus),
    .rdata      (rdata),
    .leds       (leds),
    .buttons    (buttons),
    .ledmtx_din (ledmtx_din),
    .ledmtx_cs  (ledmtx_cs),
    .ledmtx_clk (ledmtx_clk),
    .spi_mosi   (spi_mosi),
    .spi_miso   (spi_miso),
    .spi_cs_n   (spi_cs_n),
    .spi_clk    (spi_clk)
  );

  always #(CLK_HALF) clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles == CYCLE_LIMIT) begin
      $display("ERROR run stopped after %0d cycles, a test never finished", cycles);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // lane-wise merge of a masked write into the old word
  function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                               input logic [31:0] new_w,
                                               input logic [3:0]  mask);
    logic [31:0] lanes;
    lanes = {{8{mask[3]}}, {8{mask[2]}}, {8{mask[1]}}, {8{mask[0]}}};
    return (new_w & lanes) | (old_w & ~lanes);
  endfunction

  // byte the flash model returns for an address
  function automatic logic [7:0] flash_byte(input logic [23:0] addr);
    return addr[7:0] ^ 8'h5a;
  endfunction

  function automatic logic [ADDR_W-1:0] ram_addr(input logic [RAM_AW-1:0] word);
    return {{(ADDR_W-RAM_AW-2){1'b0}}, word, 2'b00};
  endfunction

  function automatic logic [ADDR_W-1:0] io_addr(input io_reg_e pos);
    logic [ADDR_W-1:0] a;
    a = '0;
    a[IO_PAGE_BIT] = 1'b1;
    a[int'(pos) + 2] = 1'b1;  // one-hot register select
    return a;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("FAIL t=%0t %s expected %h got %h", $time, name, expected, actual);
    end
  endtask

  task automatic finish_test(input string name, input int err0);
    tests_run++;
    if (errors != err0) begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errors - err0);
    end else begin
      $display("test %s: ok", name);
    end
  endtask

  task automatic bus_write(input logic [ADDR_W-1:0] addr, input logic [31:0] data,
                           input logic [3:0] mask);
    @(posedge clk);
    bus <= '{addr: addr, wdata: data, wmask: mask, rstrb: 1'b0};
    @(posedge clk);
    bus <= '0;
  endtask

  // status polls pass compare low and only use the returned word
  task automatic bus_read(input logic [ADDR_W-1:0] addr, input logic compare,
                          input logic [31:0] expected, output logic [31:0] data);
    exp_q.push_back('{chk: compare, val: expected});
    @(posedge clk);
    bus <= '{addr: addr, wdata: '0, wmask: '0, rstrb: 1'b1};
    @(posedge clk);
    bus <= '0;
    @(rd_done);
    data = rd_last;
  endtask

  always @(posedge clk) begin
    rd_due <= bus.rstrb;
  end

  // read data is due in the cycle after the strobe
  always @(negedge clk) begin : rd_check
    rd_exp_t e;
    if (rd_due) begin
      rd_last = rdata;
      if (exp_q.size() == 0) begin
        errors++;
        $display("ERROR read data arrived with no read outstanding");
      end else begin
        e = exp_q.pop_front();
        if (e.chk) begin
          check_value("rdata", e.val, rdata);
        end
      end
      -> rd_done;
    end else if (RESET) begin
      check_value("rdata", rd_last, rdata);  // last word held between reads
    end
  end

  // one-clk matrix clock pulse sampled in its middle
  always @(negedge clk) begin
    if (ledmtx_clk && !ledmtx_cs) begin
      mtx_word = {mtx_word[14:0], ledmtx_din};
      mtx_pulses++;
    end
  end

  always @(negedge clk) begin
    if (spi_cs_n) begin
      fl_bits = 0;
    end else if (spi_clk) begin
      if (fl_bits < 32) begin
        fl_cmd = {fl_cmd[30:0], spi_mosi};
      end
      fl_bits++;
      if (fl_bits == 32) begin
        fl_reply = flash_byte(fl_cmd[23:0]);
      end
    end
  end

  // reply shifts out msb first on the falling SPI clock
  always @(negedge spi_clk) begin
    if (!spi_cs_n && fl_bits >= 32 && fl_bits < 40) begin
      spi_miso <= fl_reply[39 - fl_bits];
    end
  end

  task automatic test_reset_state();
    logic [31:0] d;
    int          err0;
    err0 = errors;
    @(negedge clk);
    check_value("leds", 32'h0, {28'h0, leds});
    check_value("ledmtx_cs", 32'h1, {31'h0, ledmtx_cs});
    check_value("spi_cs_n", 32'h1, {31'h0, spi_cs_n});
    check_value("ledmtx_clk", 32'h0, {31'h0, ledmtx_clk});
    check_value("spi_clk", 32'h0, {31'h0, spi_clk});
    check_value("rdata", 32'h0, rdata);
    bus_read(io_addr(IO_MTX_CTRL), 1'b1, 32'h0, d);  // matrix busy
    bus_read(io_addr(IO_FLASH), 1'b1, 32'h0, d);     // flash busy and byte
    finish_test("reset state", err0);
  endtask

  task automatic test_ram_round_trip();
    logic [RAM_AW-1:0] words [16];
    logic [31:0]       d;
    int                err0;
    err0 = errors;
    for (int i = 0; i < 16; i++) begin
      words[i] = RAM_AW'($random(seed));
      d = $random(seed);
      bus_write(ram_addr(words[i]), d, 4'hf);
      shadow[words[i]] = d;
    end
    for (int i = 0; i < 16; i++) begin
      bus_read(ram_addr(words[i]), 1'b1, shadow[words[i]], d);
    end
    finish_test("ram round trip", err0);
  endtask

  task automatic test_byte_masks();
    logic [RAM_AW-1:0] words [12];
    logic [31:0]       d;
    logic [3:0]        m;
    int                err0;
    err0 = errors;
    for (int i = 0; i < 12; i++) begin
      words[i] = RAM_AW'($random(seed));
      d = {6'h2a, words[i], 6'h15, ~words[i]};  // known base word
      bus_write(ram_addr(words[i]), d, 4'hf);
      shadow[words[i]] = d;
      d = $random(seed);
      m = 4'($random(seed));
      bus_write(ram_addr(words[i]), d, m);
      shadow[words[i]] = merge_bytes(shadow[words[i]], d, m);
    end
    for (int i = 0; i < 12; i++) begin
      bus_read(ram_addr(words[i]), 1'b1, shadow[words[i]], d);
    end
    finish_test("byte masks", err0);
  endtask

  task automatic test_leds_buttons();
    logic [31:0] d;
    logic [5:0]  b;
    int          err0;
    err0 = errors;
    for (int i = 0; i < 4; i++) begin
      d = $random(seed);
      bus_write(io_addr(IO_LEDS), d, 4'hf);
      @(negedge clk);
      check_value("leds", {28'h0, d[3:0]}, {28'h0, leds});
      bus_read(io_addr(IO_LEDS), 1'b1, {28'h0, d[3:0]}, d);
      b = 6'($random(seed));
      @(posedge clk);
      buttons <= b;
      bus_read(io_addr(IO_BUTTONS), 1'b1, {26'h0, b}, d);
    end
    finish_test("leds and buttons", err0);
  endtask

  task automatic test_matrix();
    logic [15:0] w;
    logic [31:0] d;
    int          err0;
    err0 = errors;
    for (int i = 0; i < 4; i++) begin
      w = 16'($random(seed));
      mtx_word = 16'h0;
      mtx_pulses = 0;
      bus_write(io_addr(IO_MTX_DATA), {16'h0, w}, 4'hf);
      do begin
        bus_read(io_addr(IO_MTX_CTRL), 1'b0, 32'h0, d);
      end while (d[0]);
      check_value("mtx_word", {16'h0, w}, {16'h0, mtx_word});
      check_value("mtx_pulses", 32'd16, 32'(mtx_pulses));
    end
    finish_test("matrix transfer", err0);
  endtask

  task automatic test_flash();
    logic [23:0] a;
    logic [31:0] d;
    int          err0;
    err0 = errors;
    for (int i = 0; i < 4; i++) begin
      a = 24'($random(seed));
      fl_cmd = 32'h0;
      bus_write(io_addr(IO_FLASH), {8'h0, a}, 4'hf);
      do begin
        bus_read(io_addr(IO_FLASH), 1'b0, 32'h0, d);
      end while (d[8]);
      check_value("flash_cmd", {8'h03, a}, fl_cmd);
      check_value("flash_data", {24'h0, flash_byte(a)}, {24'h0, d[7:0]});
    end
    finish_test("flash read", err0);
  endtask

  initial begin
    bus      <= '0;
    buttons  <= 6'h0;
    spi_miso <= 1'b0;
    RESET    <= 1'b0;
    repeat (RESET_CYC) @(posedge clk);
    RESET <= 1'b1;
    test_reset_state();
    test_ram_round_trip();
    test_byte_masks();
    test_leds_buttons();
    test_matrix();
    test_flash();
    $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
design/soc_pkg.sv
design/soc_ram.sv
design/io_regs.sv
design/matrix_tx.sv
design/flash_reader.sv
design/femto_soc.sv
verification/femto_soc_asserts.sv
verification/tb_femto_soc.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the femto SoC testbench with Verilator.
# The result is taken from the simulation log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_femto_soc -f sources.f \
  || { echo "verilator build failed"; exit 1; }

./obj_dir/Vtb_femto_soc 2>&1 | tee "$LOG"

grep -q "^TESTBENCH PASSED$" "$LOG" \
  && { echo "simulation passed, log in $LOG"; exit 0; } \
  || { echo "simulation failed, log in $LOG"; exit 1; }
